// File: all.f
design/sa_geom_pkg.sv
design/sa_fsm_pkg.sv
design/sa_step_counter.sv
design/sa_sequencer.sv
design/sa_row_slice.sv
design/sa_controller_top.sv
testbench/tb_sa_controller.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_sa_controller
FILELIST  = all.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/tb_sa_controller.sv
`timescale 1ns/100ps
`default_nettype none

module tb_sa_controller
    import sa_geom_pkg::*, sa_fsm_pkg::*;
();

    localparam int N_ROWS      = 4;
    localparam int N_COLS      = 4;
    localparam int FEAT_ADDR_W = 16;
    localparam int CH_CNT_W    = 6;
    localparam int IN_CNT_W    = 16;
    localparam int CW_W        = N_ROWS * ROW_FIELD_W;

    // Worst pass has two stalls of 3 plus a wait cycle each, 5 inputs and the longest drain
    localparam int DRAIN_MAX   = 2 * (MAX_FILTER_SIZE - 1) + DRAIN_BASE;
    localparam int PASS_MAX    = 2 * 4 + N_COLS + READY_CYCLES + 5 + DRAIN_MAX + 3;
    // 8 passes over all layer tests
    localparam int TIMEOUT_CYC = 2 * (8 * PASS_MAX + 10);

    logic                   clk_i;
    logic                   sel_mux_tr_rst;
    logic [CW_W-1:0]        control_word_i;
    ncol_t                  filter_size_i;
    logic [CH_CNT_W-1:0]    total_channels_i;
    logic [IN_CNT_W-1:0]    inputs_per_pass_i;
    logic                   input_ready_i;
    logic                   weight_ready_i;
    logic                   bram_ready_i;
    logic                   load_o;
    logic                   rd_rom_ld_o;
    logic                   ready_o;
    logic                   start_op_o;
    logic                   done_o;
    logic [FEAT_ADDR_W-1:0] feat_addr_o;
    f_sel_t                 f_sel_o        [N_ROWS];
    ncol_t                  num_cols_o     [N_ROWS];
    tr_sel_t                tr_sel_o       [N_ROWS];
    logic                   en_adder_o     [N_ROWS];
    ncol_t                  column_num_o   [N_ROWS];
    ncol_t                  row_num_o      [N_ROWS];
    logic                   sel_mux_node_o [N_ROWS];

    integer seed = 74437;
    int     cycle_cnt = 0;

    sa_controller_top #(
        .N_ROWS      (N_ROWS),
        .N_COLS      (N_COLS),
        .FEAT_ADDR_W (FEAT_ADDR_W),
        .CH_CNT_W    (CH_CNT_W),
        .IN_CNT_W    (IN_CNT_W)
    ) sa_controller_top_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Timeout: the sequencer did not finish within %0d cycles", cycle_cnt);
            $display("*** TEST FAILED ***");
            $fatal(1, "simulation timed out");
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic check_val(input string test_name, input int expected, input int actual);
        if (expected != actual) begin
            $display("CHECK FAILED: %s expected %0d actual %0d", test_name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch in %s", test_name);
        end
    endtask

    // Random control word with every column count kept nonzero
    function automatic logic [CW_W-1:0] rand_word();
        logic [CW_W-1:0] w;
        w = CW_W'($random(seed));
        for (int r = 0; r < N_ROWS; r++) begin
            if (w[r*ROW_FIELD_W + NCOL_LSB +: NCOL_W] == '0) begin
                w[r*ROW_FIELD_W + NCOL_LSB] = 1'b1;
            end
        end
        return w;
    endfunction

    function automatic int field_of(input logic [CW_W-1:0] w, input int r, input int lsb,
                                    input int width);
        return int'(w >> (r * ROW_FIELD_W + lsb)) & ((1 << width) - 1);
    endfunction

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset();
        check_val("reset controls", 0,
                  int'({load_o, rd_rom_ld_o, ready_o, start_op_o, done_o}));
        check_val("reset feature address", 0, int'(feat_addr_o));
        for (int r = 0; r < N_ROWS; r++) begin
            check_val("reset row outputs", 0,
                      int'({f_sel_o[r], num_cols_o[r], tr_sel_o[r], en_adder_o[r],
                            column_num_o[r], row_num_o[r], sel_mux_node_o[r]}));
        end
    endtask

    // One whole layer; stall > 0 holds weight and BRAM ready low in the first pass
    task automatic run_layer(input string name, input int fs, input int total, input int ipp,
                             input int stall);
        int              per_pass = N_ROWS / fs;
        int              loads = 0;
        int              load_len = 0;
        int              ready_len = 0;
        int              start_len = 0;
        int              waited_w = 0;
        int              waited_b = 0;
        int              n;
        int              exp_row;
        int              col_cnt [N_ROWS] = '{default: 0};
        int              exp_col [N_ROWS] = '{default: 0};
        logic [CW_W-1:0] last_word = '0;
        logic [CW_W-1:0] prev_word = '0;
        bit              done_seen = 1'b0;
        @(negedge clk_i);
        filter_size_i     = ncol_t'(fs);
        total_channels_i  = CH_CNT_W'(total);
        inputs_per_pass_i = IN_CNT_W'(ipp);
        input_ready_i     = 1'b1;
        weight_ready_i    = (stall == 0);
        bram_ready_i      = (stall == 0);
        while (!done_seen) begin
            @(negedge clk_i);
            input_ready_i = 1'b0;
            if (load_o) begin
                load_len++;
                check_val({name, " rd_rom_ld"}, 1, int'(rd_rom_ld_o));
                prev_word      = last_word;
                last_word      = rand_word();
                control_word_i = last_word;
                // Countdown wraps after num_cols - 1, the count itself is two bits wide
                for (int r = 0; r < N_ROWS; r++) begin
                    n          = field_of(last_word, r, NCOL_LSB, NCOL_W);
                    exp_col[r] = (n - col_cnt[r]) & ((1 << NCOL_W) - 1);
                    col_cnt[r] = (col_cnt[r] == n - 1) ? 0 :
                                 (col_cnt[r] + 1) & ((1 << NCOL_W) - 1);
                end
            end else if (load_len > 0) begin
                loads++;
                check_val({name, " load length"}, N_COLS, load_len);
                load_len = 0;
                for (int r = 0; r < N_ROWS; r++) begin
                    exp_row = (r % fs) + 1;
                    check_val({name, " f_sel"}, field_of(last_word, r, F_SEL_LSB, F_SEL_W),
                              int'(f_sel_o[r]));
                    check_val({name, " num_cols"}, field_of(last_word, r, NCOL_LSB, NCOL_W),
                              int'(num_cols_o[r]));
                    check_val({name, " en_adder"}, field_of(last_word, r, EN_ADDER_BIT, 1),
                              int'(en_adder_o[r]));
                    // Transfer select lags one load behind
                    check_val({name, " tr_sel"},
                              field_of(prev_word, r, TR_SEL_LSB, TR_SEL_W),
                              int'(tr_sel_o[r]));
                    check_val({name, " column_num"}, exp_col[r], int'(column_num_o[r]));
                    check_val({name, " row_num"}, exp_row, int'(row_num_o[r]));
                    check_val({name, " sel_mux_node"}, int'(exp_row != fs),
                              int'(sel_mux_node_o[r]));
                end
            end
            if (!weight_ready_i) begin
                check_val({name, " load during weight stall"}, 0, int'(load_o));
                waited_w++;
                weight_ready_i = (waited_w == stall);
            end
            if (!bram_ready_i && loads > 0) begin
                check_val({name, " ready during BRAM stall"}, 0, int'(ready_o));
                waited_b++;
                bram_ready_i = (waited_b == stall);
            end
            if (ready_o) begin
                ready_len++;
            end
            if (start_op_o) begin
                start_len++;
            end else if (start_len > 0) begin
                check_val({name, " ready cycles"}, READY_CYCLES, ready_len);
                check_val({name, " start cycles"}, ipp + 2 * (fs - 1) + DRAIN_BASE, start_len);
                check_val({name, " feature address"}, READY_CYCLES + ipp, int'(feat_addr_o));
                ready_len = 0;
                start_len = 0;
            end
            done_seen = done_o;
        end
        check_val({name, " load phases"}, (total + per_pass - 1) / per_pass, loads);
    endtask

    initial begin
        sel_mux_tr_rst    = 1'b1;
        control_word_i    = '0;
        filter_size_i     = '0;
        total_channels_i  = '0;
        inputs_per_pass_i = '0;
        input_ready_i     = 1'b0;
        weight_ready_i    = 1'b0;
        bram_ready_i      = 1'b0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        sel_mux_tr_rst = 1'b0;
        test_reset();
        run_layer("stall_fs3", 3, 2, 5, 3);
        run_layer("fold_fs2", 2, 5, 4, 0);
        run_layer("fold_fs1", 1, 9, 2, 0);
        repeat (2) @(negedge clk_i);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/sa_controller_top.sv
`timescale 1ns/100ps
`default_nettype none

module sa_controller_top
    import sa_geom_pkg::*;
#(
    parameter int N_ROWS      = 4,
    parameter int N_COLS      = 4,
    parameter int FEAT_ADDR_W = 16,
    parameter int CH_CNT_W    = 6,
    parameter int IN_CNT_W    = 16
) (
    input  logic                          clk_i,
    input  logic                          sel_mux_tr_rst,
    input  logic [N_ROWS*ROW_FIELD_W-1:0] control_word_i,
    input  ncol_t                         filter_size_i,
    input  logic [CH_CNT_W-1:0]           total_channels_i,
    input  logic [IN_CNT_W-1:0]           inputs_per_pass_i,
    input  logic                          input_ready_i,
    input  logic                          weight_ready_i,
    input  logic                          bram_ready_i,
    output logic                          load_o,
    output logic                          rd_rom_ld_o,
    output logic                          ready_o,
    output logic                          start_op_o,
    output logic                          done_o,
    output logic [FEAT_ADDR_W-1:0]        feat_addr_o,
    output f_sel_t                        f_sel_o        [N_ROWS],
    output ncol_t                         num_cols_o     [N_ROWS],
    output tr_sel_t                       tr_sel_o       [N_ROWS],
    output logic                          en_adder_o     [N_ROWS],
    output ncol_t                         column_num_o   [N_ROWS],
    output ncol_t                         row_num_o      [N_ROWS],
    output logic                          sel_mux_node_o [N_ROWS]
);

    logic  slice_clr;
    logic  slice_ld;
    ncol_t filter_size_lat;

    sa_sequencer #(
        .N_ROWS      (N_ROWS),
        .N_COLS      (N_COLS),
        .FEAT_ADDR_W (FEAT_ADDR_W),
        .CH_CNT_W    (CH_CNT_W),
        .IN_CNT_W    (IN_CNT_W)
    ) sa_sequencer_inst (
        .clk_i             (clk_i),
        .sel_mux_tr_rst    (sel_mux_tr_rst),
        .input_ready_i     (input_ready_i),
        .weight_ready_i    (weight_ready_i),
        .bram_ready_i      (bram_ready_i),
        .filter_size_i     (filter_size_i),
        .total_channels_i  (total_channels_i),
        .inputs_per_pass_i (inputs_per_pass_i),
        .load_o            (load_o),
        .rd_rom_ld_o       (rd_rom_ld_o),
        .ready_o           (ready_o),
        .start_op_o        (start_op_o),
        .done_o            (done_o),
        .feat_addr_o       (feat_addr_o),
        .slice_clr_o       (slice_clr),
        .slice_ld_o        (slice_ld),
        .filter_size_o     (filter_size_lat)
    );

    // One slice per array row, row 0 in the lowest field
    for (genvar r = 0; r < N_ROWS; r++) begin : g_row
        sa_row_slice #(
            .ROW_INDEX (r)
        ) sa_row_slice_inst (
            .clk_i          (clk_i),
            .sel_mux_tr_rst (sel_mux_tr_rst),
            .clr_i          (slice_clr),
            .ld_i           (slice_ld),
            .row_field_i    (control_word_i[r*ROW_FIELD_W +: ROW_FIELD_W]),
            .filter_size_i  (filter_size_lat),
            .f_sel_o        (f_sel_o[r]),
            .num_cols_o     (num_cols_o[r]),
            .tr_sel_o       (tr_sel_o[r]),
            .en_adder_o     (en_adder_o[r]),
            .column_num_o   (column_num_o[r]),
            .row_num_o      (row_num_o[r]),
            .sel_mux_node_o (sel_mux_node_o[r])
        );
    end

endmodule

`default_nettype wire

// File: design/sa_row_slice.sv
`timescale 1ns/100ps
`default_nettype none

module sa_row_slice
    import sa_geom_pkg::*;
#(
    parameter int ROW_INDEX = 0
) (
    input  logic                   clk_i,
    input  logic                   sel_mux_tr_rst,
    input  logic                   clr_i,
    input  logic                   ld_i,
    input  logic [ROW_FIELD_W-1:0] row_field_i,
    input  ncol_t                  filter_size_i,
    output f_sel_t                 f_sel_o,
    output ncol_t                  num_cols_o,
    output tr_sel_t                tr_sel_o,
    output logic                   en_adder_o,
    output ncol_t                  column_num_o,
    output ncol_t                  row_num_o,
    output logic                   sel_mux_node_o
);

    f_sel_t  fld_f_sel;
    ncol_t   fld_ncol;
    tr_sel_t fld_tr_sel;
    logic    fld_en_adder;

    // Transfer select waits one load in this stage
    tr_sel_t tr_pre_q;
    ncol_t   col_cnt_q;

    assign fld_f_sel    = row_field_i[F_SEL_LSB +: F_SEL_W];
    assign fld_ncol     = row_field_i[NCOL_LSB +: NCOL_W];
    assign fld_tr_sel   = row_field_i[TR_SEL_LSB +: TR_SEL_W];
    assign fld_en_adder = row_field_i[EN_ADDER_BIT];

    ////////////////////////////////////////////////////////////
    // Control registers and column countdown
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            f_sel_o      <= '0;
            num_cols_o   <= '0;
            en_adder_o   <= 1'b0;
            tr_pre_q     <= '0;
            tr_sel_o     <= '0;
            col_cnt_q    <= '0;
            column_num_o <= '0;
        end else if (clr_i) begin
            f_sel_o      <= '0;
            num_cols_o   <= '0;
            en_adder_o   <= 1'b0;
            tr_pre_q     <= '0;
            tr_sel_o     <= '0;
            col_cnt_q    <= '0;
            column_num_o <= '0;
        end else if (ld_i) begin
            f_sel_o      <= fld_f_sel;
            num_cols_o   <= fld_ncol;
            en_adder_o   <= fld_en_adder;
            tr_pre_q     <= fld_tr_sel;
            tr_sel_o     <= tr_pre_q;
            column_num_o <= fld_ncol - col_cnt_q;
            // Wraps after the last column of this row's filter
            if (col_cnt_q == fld_ncol - ncol_t'(1)) begin
                col_cnt_q <= '0;
            end else begin
                col_cnt_q <= col_cnt_q + ncol_t'(1);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Row position inside the folded filter
    ////////////////////////////////////////////////////////////

    // Zero while no filter size is latched
    always_comb begin
        row_num_o = '0;
        for (int f = 1; f <= MAX_FILTER_SIZE; f++) begin
            if (filter_size_i == ncol_t'(f)) begin
                row_num_o = ncol_t'((ROW_INDEX % f) + 1);
            end
        end
    end

    // Last row of a filter closes the adder chain
    assign sel_mux_node_o = (row_num_o != filter_size_i);

    assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        (ld_i && $past(ld_i)) |-> (num_cols_o != '0))
        else $error("row %0d loaded a zero column count", ROW_INDEX);

endmodule

`default_nettype wire

// File: design/sa_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module sa_sequencer
    import sa_geom_pkg::*, sa_fsm_pkg::*;
#(
    parameter int N_ROWS      = 4,
    parameter int N_COLS      = 4,
    parameter int FEAT_ADDR_W = 16,
    parameter int CH_CNT_W    = 6,
    parameter int IN_CNT_W    = 16
) (
    input  logic                   clk_i,
    input  logic                   sel_mux_tr_rst,
    input  logic                   input_ready_i,
    input  logic                   weight_ready_i,
    input  logic                   bram_ready_i,
    input  ncol_t                  filter_size_i,
    input  logic [CH_CNT_W-1:0]    total_channels_i,
    input  logic [IN_CNT_W-1:0]    inputs_per_pass_i,
    output logic                   load_o,
    output logic                   rd_rom_ld_o,
    output logic                   ready_o,
    output logic                   start_op_o,
    output logic                   done_o,
    output logic [FEAT_ADDR_W-1:0] feat_addr_o,
    output logic                   slice_clr_o,
    output logic                   slice_ld_o,
    output ncol_t                  filter_size_o
);

    localparam int LOAD_W    = $clog2(N_COLS + 1);
    localparam int READY_W   = $clog2(READY_CYCLES + 1);
    localparam int DRAIN_MAX = 2 * (MAX_FILTER_SIZE - 1) + DRAIN_BASE;
    localparam int DRAIN_W   = $clog2(DRAIN_MAX + 1);

    seq_state_t state_q;
    seq_state_t state_d;

    // Layer configuration, captured when leaving IDLE
    ncol_t               filter_size_q;
    logic [CH_CNT_W-1:0] total_ch_q;
    logic [IN_CNT_W-1:0] ipp_q;
    logic [CH_CNT_W-1:0] ch_cnt_q;

    logic [LOAD_W-1:0]   load_cnt;
    logic [READY_W-1:0]  ready_cnt;
    logic [DRAIN_W-1:0]  drain_cnt;
    logic [IN_CNT_W-1:0] in_cnt;

    logic [DRAIN_W-1:0]  drain_len;
    logic [CH_CNT_W-1:0] ch_step;
    logic [CH_CNT_W-1:0] ch_next;
    logic                layer_start;
    logic                load_last;
    logic                ready_last;
    logic                start_last;
    logic                drain_last;

    ////////////////////////////////////////////////////////////
    // Phase length decode
    ////////////////////////////////////////////////////////////

    assign drain_len = DRAIN_W'(2 * (int'(filter_size_q) - 1) + DRAIN_BASE);

    // Channels finished per pass, N_ROWS / filter size
    always_comb begin
        ch_step = '0;
        for (int f = 1; f <= MAX_FILTER_SIZE; f++) begin
            if (filter_size_q == ncol_t'(f)) begin
                ch_step = CH_CNT_W'(N_ROWS / f);
            end
        end
    end

    assign ch_next     = ch_cnt_q + ch_step;
    assign layer_start = (state_q == IDLE) && input_ready_i;
    assign load_last   = (load_cnt == LOAD_W'(N_COLS - 1));
    assign ready_last  = (ready_cnt == READY_W'(READY_CYCLES - 1));
    assign start_last  = (in_cnt == ipp_q - IN_CNT_W'(1));
    assign drain_last  = (drain_cnt == drain_len - DRAIN_W'(1));

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (input_ready_i && weight_ready_i) begin
                    state_d = LOAD;
                end else if (input_ready_i) begin
                    state_d = WAIT_WEIGHT;
                end
            end
            WAIT_WEIGHT: begin
                if (weight_ready_i) begin
                    state_d = LOAD;
                end
            end
            LOAD: begin
                if (load_last) begin
                    state_d = WAIT_BRAM;
                end
            end
            WAIT_BRAM: begin
                if (bram_ready_i) begin
                    state_d = READY;
                end
            end
            READY: begin
                if (ready_last) begin
                    state_d = START;
                end
            end
            START: begin
                if (start_last) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                // Layer done once the new count reaches the total
                if (drain_last) begin
                    state_d = (ch_next >= total_ch_q) ? DONE : WAIT_WEIGHT;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            filter_size_q <= '0;
            total_ch_q    <= '0;
            ipp_q         <= '0;
        end else if (layer_start) begin
            filter_size_q <= filter_size_i;
            total_ch_q    <= total_channels_i;
            ipp_q         <= inputs_per_pass_i;
        end
    end

    // One increment per pass, on the last drain cycle
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            ch_cnt_q <= '0;
        end else if (layer_start) begin
            ch_cnt_q <= '0;
        end else if ((state_q == DRAIN) && drain_last) begin
            ch_cnt_q <= ch_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // Phase counters
    ////////////////////////////////////////////////////////////

    sa_step_counter #(.W(LOAD_W)) load_cnt_inst (
        .clk_i          (clk_i),
        .sel_mux_tr_rst (sel_mux_tr_rst),
        .clr_i          (state_q != LOAD),
        .en_i           (state_q == LOAD),
        .count_o        (load_cnt)
    );

    sa_step_counter #(.W(READY_W)) ready_cnt_inst (
        .clk_i          (clk_i),
        .sel_mux_tr_rst (sel_mux_tr_rst),
        .clr_i          (state_q != READY),
        .en_i           (state_q == READY),
        .count_o        (ready_cnt)
    );

    sa_step_counter #(.W(DRAIN_W)) drain_cnt_inst (
        .clk_i          (clk_i),
        .sel_mux_tr_rst (sel_mux_tr_rst),
        .clr_i          (state_q != DRAIN),
        .en_i           (state_q == DRAIN),
        .count_o        (drain_cnt)
    );

    // Feature address restarts with every weight load
    sa_step_counter #(.W(FEAT_ADDR_W)) feat_addr_inst (
        .clk_i          (clk_i),
        .sel_mux_tr_rst (sel_mux_tr_rst),
        .clr_i          (state_q == LOAD),
        .en_i           ((state_q == READY) || (state_q == START)),
        .count_o        (feat_addr_o)
    );

    sa_step_counter #(.W(IN_CNT_W)) in_cnt_inst (
        .clk_i          (clk_i),
        .sel_mux_tr_rst (sel_mux_tr_rst),
        .clr_i          (state_q != START),
        .en_i           (state_q == START),
        .count_o        (in_cnt)
    );

    assign load_o        = (state_q == LOAD);
    assign rd_rom_ld_o   = (state_q == LOAD);
    assign slice_ld_o    = (state_q == LOAD);
    assign slice_clr_o   = (state_q == IDLE);
    assign ready_o       = (state_q == READY);
    assign start_op_o    = (state_q == START) || (state_q == DRAIN);
    assign done_o        = (state_q == DONE);
    assign filter_size_o = filter_size_q;

    // Filter size captured in IDLE must stay legal for the whole layer
    assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        (state_q != IDLE) |-> (filter_size_q >= 1) && (filter_size_q <= MAX_FILTER_SIZE))
        else $error("latched filter size out of range");

    assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        (state_q == LOAD) [*N_COLS] |=> (state_q != LOAD))
        else $error("LOAD phase longer than N_COLS cycles");

endmodule

`default_nettype wire

// File: design/sa_step_counter.sv
`timescale 1ns/100ps
`default_nettype none

module sa_step_counter #(
    parameter int W = 4
) (
    input  logic         clk_i,
    input  logic         sel_mux_tr_rst,
    input  logic         clr_i,
    input  logic         en_i,
    output logic [W-1:0] count_o
);

    // Clear has priority over the step
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            count_o <= '0;
        end else if (clr_i) begin
            count_o <= '0;
        end else if (en_i) begin
            count_o <= count_o + W'(1);
        end
    end

endmodule

`default_nettype wire

// File: design/sa_fsm_pkg.sv
`default_nettype none

package sa_fsm_pkg;

    // Phases of one pass over the array
    typedef enum logic [2:0] {
        IDLE,
        WAIT_WEIGHT,
        LOAD,
        WAIT_BRAM,
        READY,
        START,
        DRAIN,
        DONE
    } seq_state_t;

    // Priming phase before the operands stream in
    localparam int READY_CYCLES = 3;

    // Drain time is 2 * (filter size - 1) + DRAIN_BASE
    localparam int DRAIN_BASE = 6;

endpackage

`default_nettype wire

// File: design/sa_geom_pkg.sv
`default_nettype none

package sa_geom_pkg;

    // Largest filter the array can fold onto its rows
    localparam int MAX_FILTER_SIZE = 3;

    // Field widths of one row inside a control word
    localparam int F_SEL_W  = 2;
    localparam int NCOL_W   = 2;
    localparam int TR_SEL_W = 2;

    // Three fields plus the adder-node enable bit
    localparam int ROW_FIELD_W = F_SEL_W + NCOL_W + TR_SEL_W + 1;

    // Field positions, low end first
    localparam int F_SEL_LSB    = 0;
    localparam int NCOL_LSB     = F_SEL_LSB + F_SEL_W;
    localparam int TR_SEL_LSB   = NCOL_LSB + NCOL_W;
    localparam int EN_ADDER_BIT = TR_SEL_LSB + TR_SEL_W;

    typedef logic [F_SEL_W-1:0]  f_sel_t;
    typedef logic [NCOL_W-1:0]   ncol_t;
    typedef logic [TR_SEL_W-1:0] tr_sel_t;

endpackage

`default_nettype wire
